/* verilog/scope_acq_pkg.sv */
// Oscilloscope acquisition package
// Shared sample and address widths, capture limits and the enums
// for the trigger settings and the acquisition state

`default_nettype none

package scope_acq_pkg;

  // ------------------------------------------------------------------
  // Sample and memory geometry
  // ------------------------------------------------------------------

  localparam int SAMPLE_WIDTH      = 8;                  // One ADC byte
  localparam int SAMPLE_WORD_WIDTH = 4 * SAMPLE_WIDTH;   // Four streams per word
  localparam int ADDRESS_WIDTH     = 12;
  localparam int MEMORY_DEPTH      = 1 << ADDRESS_WIDTH; // 4096 words

  // Trigger is only accepted once this much pre-trigger data is stored
  localparam logic [ADDRESS_WIDTH-1:0] HALF_WAY_ADDRESS     = 12'd1500;
  // Words written after the trigger word before capture stops
  localparam logic [ADDRESS_WIDTH-1:0] POST_TRIGGER_SAMPLES = 12'd1500;

  localparam int TIME_BASE_WIDTH = 32;                   // Auto mode timeout counter

  // ------------------------------------------------------------------
  // Trigger settings
  // ------------------------------------------------------------------

  typedef enum logic {
    EDGE_RISING  = 1'b0,
    EDGE_FALLING = 1'b1
  } trigger_edge_t;

  typedef enum logic {
    MODE_AUTO   = 1'b0,   // Stops on time base timeout as well
    MODE_NORMAL = 1'b1    // Waits for a real trigger
  } trigger_mode_t;

  typedef enum logic {
    CHANNEL_1 = 1'b0,
    CHANNEL_2 = 1'b1
  } trigger_channel_t;

  // Acquisition progress
  typedef enum logic [1:0] {
    ACQ_PRE_FILL     = 2'd0,  // Filling pre-trigger history
    ACQ_ARMED        = 2'd1,  // Waiting for an edge
    ACQ_POST_TRIGGER = 2'd2,  // Filling post-trigger region
    ACQ_DONE         = 2'd3   // Writing stopped until reset
  } acq_state_t;

endpackage

`default_nettype wire

/* verilog/sample_memory.sv */
// Circular sample store
// One write port on the sample clock and a read port with one cycle
// of latency for readback after capture has stopped

`default_nettype none

module sample_memory (
  input  wire                                        sample_write_clock,
  input  wire                                        i_write_enable,
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]     i_write_address,
  input  wire  [scope_acq_pkg::SAMPLE_WORD_WIDTH-1:0] i_write_data,
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]     i_read_address,
  output logic [scope_acq_pkg::SAMPLE_WORD_WIDTH-1:0] o_read_data
);

  // ------------------------------------------------------------------
  // Storage array
  // ------------------------------------------------------------------

  // Word layout is {adc2B, adc2A, adc1B, adc1A}
  logic [scope_acq_pkg::SAMPLE_WORD_WIDTH-1:0] r_memory [0:scope_acq_pkg::MEMORY_DEPTH-1];

  // Write side
  always_ff @(posedge sample_write_clock)
  begin
    if (i_write_enable)
    begin
      r_memory[i_write_address] <= i_write_data;  // Wraps naturally at 4096
    end
  end

  // ------------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------------

  // Registered read so the array maps onto block RAM
  always_ff @(posedge sample_write_clock)
  begin
    o_read_data <= r_memory[i_read_address];  // Valid one cycle after address
  end

endmodule

`default_nettype wire

/* verilog/trigger_detector.sv */
// Trigger edge detector
// Picks the A stream of the chosen channel, keeps the current and
// previous sample and flags a crossing of the trigger level

`default_nettype none

module trigger_detector (
  input  wire                                       sample_write_clock,
  input  wire                                       sample_system_reset,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]    i_adc1a_d,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]    i_adc2a_d,
  input  wire  scope_acq_pkg::trigger_channel_t     i_trigger_channel,
  input  wire  scope_acq_pkg::trigger_edge_t        i_trigger_edge,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]    i_trigger_level,
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]   i_write_address,
  output logic                                      o_edge_hit,
  output logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]   o_edge_address
);

  logic [scope_acq_pkg::SAMPLE_WIDTH-1:0]  w_selected_sample;
  logic [scope_acq_pkg::SAMPLE_WIDTH-1:0]  r_current_sample;
  logic [scope_acq_pkg::SAMPLE_WIDTH-1:0]  r_previous_sample;
  logic [scope_acq_pkg::ADDRESS_WIDTH-1:0] r_current_address;
  logic                                    r_current_valid;   // Current holds a real sample
  logic                                    r_previous_valid;  // Previous holds one too
  logic                                    w_previous_below;
  logic                                    w_current_below;
  logic                                    w_rise_detect;
  logic                                    w_fall_detect;

  // ------------------------------------------------------------------
  // Sample history
  // ------------------------------------------------------------------

  assign w_selected_sample = (i_trigger_channel == scope_acq_pkg::CHANNEL_2) ?
                             i_adc2a_d : i_adc1a_d;

  // Data registers carry no reset, the valid bits cover them
  always_ff @(posedge sample_write_clock)
  begin
    r_previous_sample <= r_current_sample;
    r_current_sample  <= w_selected_sample;
    r_current_address <= i_write_address;    // Address this sample is stored at
  end

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
    begin
      r_current_valid  <= 1'b0;
      r_previous_valid <= 1'b0;
    end
    else
    begin
      r_current_valid  <= 1'b1;
      r_previous_valid <= r_current_valid;
    end
  end

  // ------------------------------------------------------------------
  // Level crossing
  // ------------------------------------------------------------------

  assign w_previous_below = r_previous_sample < i_trigger_level;
  assign w_current_below  = r_current_sample  < i_trigger_level;

  assign w_rise_detect = w_previous_below  & ~w_current_below;  // prev < lvl, cur >= lvl
  assign w_fall_detect = ~w_previous_below & w_current_below;   // prev >= lvl, cur < lvl

  // Hit lasts the one cycle that the crossing pair is held
  assign o_edge_hit = r_previous_valid &
                      ((i_trigger_edge == scope_acq_pkg::EDGE_RISING) ?
                       w_rise_detect : w_fall_detect);

  assign o_edge_address = r_current_address;

  // After a crossing the previous sample sits on the far side of the level
  assert property (@(posedge sample_write_clock) disable iff (sample_system_reset)
    o_edge_hit ##1 ($stable(i_trigger_level) && $stable(i_trigger_edge)) |-> !o_edge_hit)
    else $error("Edge hit held for two cycles on a fixed level");

endmodule

`default_nettype wire

/* verilog/acquisition_control.sv */
// Acquisition controller
// Runs the circular write address, the auto mode time base and the
// capture state machine, and latches where the trigger landed

`default_nettype none

module acquisition_control (
  input  wire                                        sample_write_clock,
  input  wire                                        sample_system_reset,
  input  wire  scope_acq_pkg::trigger_mode_t         i_trigger_mode,
  input  wire  [scope_acq_pkg::TIME_BASE_WIDTH-1:0]  i_time_base_set,
  input  wire                                        i_edge_hit,
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]    i_edge_address,
  output logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]    o_write_address,
  output logic                                       o_write_enable,
  output logic                                       o_triggered,
  output logic                                       o_sampling_done,
  output logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]    o_trigger_address
);

  scope_acq_pkg::acq_state_t                 r_state;
  scope_acq_pkg::acq_state_t                 w_next_state;

  logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]   r_write_address;
  logic [scope_acq_pkg::TIME_BASE_WIDTH-1:0] r_time_base_count;
  logic                                      r_time_base_timeout;
  logic                                      w_auto_timeout;
  logic                                      w_capture;
  logic                                      r_triggered;
  logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]   r_trigger_address;
  logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]   w_last_address;

  // ------------------------------------------------------------------
  // Write address
  // ------------------------------------------------------------------

  // Counts one per stored word and freezes once writing stops
  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
    begin
      r_write_address <= '0;
    end
    else if (o_write_enable)
    begin
      r_write_address <= r_write_address + 1'b1;  // Rolls over 4095 -> 0
    end
  end

  // ------------------------------------------------------------------
  // Time base
  // ------------------------------------------------------------------

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
    begin
      r_time_base_count   <= '0;
      r_time_base_timeout <= 1'b0;
    end
    else
    begin
      r_time_base_count   <= r_time_base_count + 1'b1;
      // Registered compare, adds a cycle before done
      r_time_base_timeout <= r_time_base_count > i_time_base_set;
    end
  end

  // Timeout only counts in auto mode
  assign w_auto_timeout = (i_trigger_mode == scope_acq_pkg::MODE_AUTO) && r_time_base_timeout;

  // Final word of the post-trigger region, modulo the memory size
  assign w_last_address = r_trigger_address + scope_acq_pkg::POST_TRIGGER_SAMPLES;

  // ------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------

  always_comb
  begin
    w_next_state = r_state;
    case (r_state)
      scope_acq_pkg::ACQ_PRE_FILL:
      begin
        if (r_write_address >= scope_acq_pkg::HALF_WAY_ADDRESS)
        begin
          w_next_state = scope_acq_pkg::ACQ_ARMED;       // Enough history stored
        end
      end
      scope_acq_pkg::ACQ_ARMED:
      begin
        if (i_edge_hit)
        begin
          w_next_state = scope_acq_pkg::ACQ_POST_TRIGGER;
        end
      end
      scope_acq_pkg::ACQ_POST_TRIGGER:
      begin
        if (r_write_address == w_last_address)
        begin
          w_next_state = scope_acq_pkg::ACQ_DONE;        // This edge writes the last word
        end
      end
      scope_acq_pkg::ACQ_DONE:
      begin
        w_next_state = scope_acq_pkg::ACQ_DONE;          // Held until reset
      end
      default:
      begin
        w_next_state = scope_acq_pkg::ACQ_PRE_FILL;
      end
    endcase

    // Auto mode timeout overrides whatever capture was doing
    if (w_auto_timeout)
    begin
      w_next_state = scope_acq_pkg::ACQ_DONE;
    end
  end

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
    begin
      r_state <= scope_acq_pkg::ACQ_PRE_FILL;
    end
    else
    begin
      r_state <= w_next_state;
    end
  end

  // ------------------------------------------------------------------
  // Trigger capture
  // ------------------------------------------------------------------

  // Only a hit that actually moves us into post-trigger is taken
  assign w_capture = (r_state == scope_acq_pkg::ACQ_ARMED) &&
                     (w_next_state == scope_acq_pkg::ACQ_POST_TRIGGER);

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
    begin
      r_triggered       <= 1'b0;
      r_trigger_address <= '0;
    end
    else if (w_capture)
    begin
      r_triggered       <= 1'b1;
      r_trigger_address <= i_edge_address;  // Address of the crossing sample
    end
  end

  // Outputs
  assign o_write_address   = r_write_address;
  assign o_write_enable    = (r_state != scope_acq_pkg::ACQ_DONE);
  assign o_sampling_done   = (r_state == scope_acq_pkg::ACQ_DONE);
  assign o_triggered       = r_triggered;
  assign o_trigger_address = r_trigger_address;

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  assert property (@(posedge sample_write_clock) disable iff (sample_system_reset)
    o_sampling_done |=> o_sampling_done)
    else $error("Sampling done dropped without reset");

  assert property (@(posedge sample_write_clock) disable iff (sample_system_reset)
    o_triggered |=> $stable(o_trigger_address))
    else $error("Trigger address changed after trigger");

  // Done must also freeze the write address
  assert property (@(posedge sample_write_clock) disable iff (sample_system_reset)
    o_sampling_done |-> !o_write_enable ##1 $stable(o_write_address))
    else $error("Memory still written after done");

endmodule

`default_nettype wire

/* verilog/scope_acquisition.sv */
// Oscilloscope acquisition top level
// Packs the four ADC bytes into one word and ties together the sample
// store, the trigger detector and the capture controller

`default_nettype none

module scope_acquisition (
  input  wire                                        sample_write_clock,
  input  wire                                        sample_system_reset,
  // ADC sample bytes
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc1a_d,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc1b_d,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc2a_d,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc2b_d,
  // Trigger settings, held for the whole acquisition
  input  wire  scope_acq_pkg::trigger_mode_t          i_trigger_mode,
  input  wire  scope_acq_pkg::trigger_edge_t          i_trigger_edge,
  input  wire  scope_acq_pkg::trigger_channel_t       i_trigger_channel,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_trigger_level,
  input  wire  [scope_acq_pkg::TIME_BASE_WIDTH-1:0]   i_time_base_set,
  // Readback
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]     i_read_address,
  output logic [scope_acq_pkg::SAMPLE_WORD_WIDTH-1:0] o_read_data,
  // Status
  output logic                                       o_triggered,
  output logic                                       o_sampling_done,
  output logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]     o_trigger_address
);

  logic [scope_acq_pkg::SAMPLE_WORD_WIDTH-1:0] w_sample_word;
  logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]     w_write_address;
  logic                                        w_write_enable;
  logic                                        w_edge_hit;
  logic [scope_acq_pkg::ADDRESS_WIDTH-1:0]     w_edge_address;

  // adc1A ends up in the lowest byte
  assign w_sample_word = {i_adc2b_d, i_adc2a_d, i_adc1b_d, i_adc1a_d};

  // ------------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------------

  sample_memory u_memory (
    .sample_write_clock (sample_write_clock),
    .i_write_enable     (w_write_enable),
    .i_write_address    (w_write_address),
    .i_write_data       (w_sample_word),
    .i_read_address     (i_read_address),
    .o_read_data        (o_read_data)
  );

  trigger_detector u_trigger (
    .sample_write_clock  (sample_write_clock),
    .sample_system_reset (sample_system_reset),
    .i_adc1a_d           (i_adc1a_d),
    .i_adc2a_d           (i_adc2a_d),
    .i_trigger_channel   (i_trigger_channel),
    .i_trigger_edge      (i_trigger_edge),
    .i_trigger_level     (i_trigger_level),
    .i_write_address     (w_write_address),    // Tags each sample with its slot
    .o_edge_hit          (w_edge_hit),
    .o_edge_address      (w_edge_address)
  );

  acquisition_control u_control (
    .sample_write_clock  (sample_write_clock),
    .sample_system_reset (sample_system_reset),
    .i_trigger_mode      (i_trigger_mode),
    .i_time_base_set     (i_time_base_set),
    .i_edge_hit          (w_edge_hit),
    .i_edge_address      (w_edge_address),
    .o_write_address     (w_write_address),
    .o_write_enable      (w_write_enable),
    .o_triggered         (o_triggered),
    .o_sampling_done     (o_sampling_done),
    .o_trigger_address   (o_trigger_address)
  );

endmodule

`default_nettype wire

/* tests/acq_checker.sv */
// Acquisition checker
// Watches the DUT ports, keeps a model of the stored words and compares
// reset values, trigger and done timing and readback data

`default_nettype none

module acq_checker (
  input  wire                                        sample_write_clock,
  input  wire                                        sample_system_reset,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc1a_d,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc1b_d,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc2a_d,
  input  wire  [scope_acq_pkg::SAMPLE_WIDTH-1:0]      i_adc2b_d,
  input  wire  scope_acq_pkg::trigger_mode_t          i_trigger_mode,
  input  wire  [scope_acq_pkg::TIME_BASE_WIDTH-1:0]   i_time_base_set,
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]     i_read_address,
  input  wire  [scope_acq_pkg::SAMPLE_WORD_WIDTH-1:0] i_read_data,
  input  wire                                        i_triggered,
  input  wire                                        i_sampling_done,
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]     i_trigger_address,
  // Expected outcome of the running scenario
  input  wire                                        i_exp_triggered,
  input  wire  [scope_acq_pkg::ADDRESS_WIDTH-1:0]     i_exp_trigger_address,
  input  wire                                        i_read_check,       // Readback sweep active
  output int                                         o_error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [scope_acq_pkg::SAMPLE_WORD_WIDTH-1:0] model_memory [0:scope_acq_pkg::MEMORY_DEPTH-1];
  int                                      error_count = 0;
  int                                      edge_count = 0;       // Edge k since reset release
  logic                                    reset_prev = 1'b0;
  logic                                    triggered_prev = 1'b0;
  logic                                    done_prev = 1'b0;
  logic                                    read_pending = 1'b0;  // Data due this edge
  logic [scope_acq_pkg::ADDRESS_WIDTH-1:0] read_address_prev = '0;

  assign o_error_count = error_count;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("Mismatch at %0t ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string text);
    error_count++;
    $display("Error at %0t ns: %s", $time, text);
  endtask

  // ------------------------------------------------------------------
  // Monitor
  // ------------------------------------------------------------------

  always @(posedge sample_write_clock)
  begin
    if (reset_prev)                                   // Outputs settled by a reset edge
    begin
      if (i_triggered !== 1'b0) report_mismatch("o_triggered", 32'd0, 32'(i_triggered));
      if (i_sampling_done !== 1'b0) report_mismatch("o_sampling_done", 32'd0,
                                                    32'(i_sampling_done));
      if (i_trigger_address !== '0) report_mismatch("o_trigger_address", 32'd0,
                                                    32'(i_trigger_address));
    end
    if (!sample_system_reset)
    begin
      // Word at edge k lands at k mod depth up to the last post-trigger word
      if (i_exp_triggered && edge_count <= int'(i_exp_trigger_address) +
          int'(scope_acq_pkg::POST_TRIGGER_SAMPLES))
      begin
        model_memory[edge_count[scope_acq_pkg::ADDRESS_WIDTH-1:0]] <=
          {i_adc2b_d, i_adc2a_d, i_adc1b_d, i_adc1a_d};
      end
      if (i_triggered && !triggered_prev)
      begin
        if (!i_exp_triggered)
          report_failure("trigger fired although it should have been ignored");
        else if (i_trigger_address !== i_exp_trigger_address)
          report_mismatch("o_trigger_address", 32'(i_exp_trigger_address),
                          32'(i_trigger_address));
        else if (edge_count != int'(i_exp_trigger_address) + 2)  // Hit, then capture
          report_failure($sformatf("o_triggered rose at edge %0d, expected edge %0d",
                                   edge_count, int'(i_exp_trigger_address) + 2));
      end
      if (i_sampling_done && !done_prev)
      begin
        if (i_exp_triggered)
        begin
          // Trigger status still shown when capture ends
          if (i_triggered !== 1'b1)
            report_mismatch("o_triggered", 32'd1, 32'(i_triggered));
          if (i_trigger_address !== i_exp_trigger_address)
            report_mismatch("o_trigger_address", 32'(i_exp_trigger_address),
                            32'(i_trigger_address));
          // Done is visible one edge after the last word is written
          if (edge_count != int'(i_exp_trigger_address) +
              int'(scope_acq_pkg::POST_TRIGGER_SAMPLES) + 1)
            report_failure($sformatf("o_sampling_done rose at edge %0d, not after word %0d",
                                     edge_count, int'(i_exp_trigger_address) +
                                     int'(scope_acq_pkg::POST_TRIGGER_SAMPLES)));
        end
        else if (i_trigger_mode == scope_acq_pkg::MODE_AUTO)
        begin
          if (edge_count < int'(i_time_base_set) + 2 || edge_count > int'(i_time_base_set) + 4)
            report_failure($sformatf("auto timeout done at edge %0d, time base %0d",
                                     edge_count, i_time_base_set));
          if (i_trigger_address !== '0)                // No trigger came before timeout
            report_mismatch("o_trigger_address", 32'd0, 32'(i_trigger_address));
        end
        else
          report_failure("o_sampling_done rose in normal mode without a trigger");
      end
      edge_count <= edge_count + 1;
    end
    else
    begin
      edge_count <= 0;
    end

    // Readback, one cycle of latency
    if (read_pending && i_read_data !== model_memory[read_address_prev])
    begin
      report_mismatch($sformatf("o_read_data[%0d]", read_address_prev),
                      model_memory[read_address_prev], i_read_data);
    end
    read_pending      <= i_read_check;
    read_address_prev <= i_read_address;
    reset_prev        <= sample_system_reset;
    triggered_prev    <= i_triggered;
    done_prev         <= i_sampling_done;
  end

endmodule

`default_nettype wire

/* tests/tb_scope_acquisition.sv */
// Scope acquisition testbench
// Runs each row of the scenario table, drives the ADC step waveform,
// waits for done and sweeps the readback port after a capture

`default_nettype none

module tb_scope_acquisition;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_SCENARIOS = 4;
  localparam int          DONE_TIMEOUT  = 8000;      // Cycles
  localparam int          READ_FIRST    = 1000;
  localparam int          READ_LAST     = 3500;
  localparam logic [31:0] LCG_SEED      = 32'h403c_4e89;
  localparam logic [7:0]  STEP_SWING    = 8'h30;     // Step distance from the level

  typedef struct packed {
    scope_acq_pkg::trigger_mode_t    mode;
    scope_acq_pkg::trigger_edge_t    trig_edge;
    scope_acq_pkg::trigger_channel_t channel;
    logic [7:0]                      level;
    logic [31:0]                     time_base;
    logic [31:0]                     step_index;  // First sample past the step
    logic                            exp_triggered;
    logic                            exp_done;
    logic [11:0]                     exp_trigger_address;
  } scenario_t;

  // mode, edge, channel, level, time base, step, triggered, done, trigger address
  scenario_t scenario_table [NUM_SCENARIOS] = '{
    '{scope_acq_pkg::MODE_NORMAL, scope_acq_pkg::EDGE_RISING, scope_acq_pkg::CHANNEL_1,
      8'h80, 32'd0, 32'd2000, 1'b1, 1'b1, 12'd2000},
    '{scope_acq_pkg::MODE_NORMAL, scope_acq_pkg::EDGE_FALLING, scope_acq_pkg::CHANNEL_2,
      8'h60, 32'd0, 32'd2000, 1'b1, 1'b1, 12'd2000},
    // Step lands before the half way address
    '{scope_acq_pkg::MODE_NORMAL, scope_acq_pkg::EDGE_RISING, scope_acq_pkg::CHANNEL_1,
      8'h80, 32'd0, 32'd800, 1'b0, 1'b0, 12'd0},
    // No step at all, time base ends it
    '{scope_acq_pkg::MODE_AUTO, scope_acq_pkg::EDGE_RISING, scope_acq_pkg::CHANNEL_1,
      8'h80, 32'd1000, 32'hffff_ffff, 1'b0, 1'b1, 12'd0}
  };

  logic                             sample_write_clock = 1'b0;
  logic                             sample_system_reset;
  logic [7:0]                       adc1a_d, adc1b_d, adc2a_d, adc2b_d;
  scope_acq_pkg::trigger_mode_t     trigger_mode;
  scope_acq_pkg::trigger_edge_t     trigger_edge;
  scope_acq_pkg::trigger_channel_t  trigger_channel;
  logic [7:0]                       trigger_level;
  logic [31:0]                      time_base_set;
  logic [11:0]                      read_address;
  logic [31:0]                      read_data;
  logic                             triggered, sampling_done;
  logic [11:0]                      trigger_address;
  logic                             exp_triggered, read_check;
  logic [11:0]                      exp_trigger_address;
  int                               checker_errors;
  int                               tb_errors;
  logic [31:0]                      lcg_state;
  scenario_t                        row;              // Scenario being run

  always #50 sample_write_clock = ~sample_write_clock;  // 100 ns period

  scope_acquisition u_dut (
    .sample_write_clock (sample_write_clock), .sample_system_reset (sample_system_reset),
    .i_adc1a_d (adc1a_d), .i_adc1b_d (adc1b_d), .i_adc2a_d (adc2a_d), .i_adc2b_d (adc2b_d),
    .i_trigger_mode (trigger_mode), .i_trigger_edge (trigger_edge),
    .i_trigger_channel (trigger_channel), .i_trigger_level (trigger_level),
    .i_time_base_set (time_base_set), .i_read_address (read_address),
    .o_read_data (read_data), .o_triggered (triggered),
    .o_sampling_done (sampling_done), .o_trigger_address (trigger_address)
  );

  acq_checker u_checker (
    .sample_write_clock (sample_write_clock), .sample_system_reset (sample_system_reset),
    .i_adc1a_d (adc1a_d), .i_adc1b_d (adc1b_d), .i_adc2a_d (adc2a_d), .i_adc2b_d (adc2b_d),
    .i_trigger_mode (trigger_mode), .i_time_base_set (time_base_set),
    .i_read_address (read_address), .i_read_data (read_data),
    .i_triggered (triggered), .i_sampling_done (sampling_done),
    .i_trigger_address (trigger_address), .i_exp_triggered (exp_triggered),
    .i_exp_trigger_address (exp_trigger_address), .i_read_check (read_check),
    .o_error_count (checker_errors)
  );

  // ------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    lcg_next = state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Step waveform on the selected A stream
  function automatic logic [7:0] step_sample(input int unsigned k, input scenario_t sc);
    logic high_side;
    high_side = (k >= sc.step_index) ^ (sc.trig_edge == scope_acq_pkg::EDGE_FALLING);
    step_sample = high_side ? sc.level + STEP_SWING : sc.level - STEP_SWING;
  endfunction

  // Sample for edge k, driven one cycle ahead
  task automatic drive_sample(input int unsigned k);
    logic [7:0] a_byte;
    a_byte    = step_sample(k, row);
    lcg_state = lcg_next(lcg_state);                 // Value k of the sequence
    adc1a_d   = (row.channel == scope_acq_pkg::CHANNEL_1) ? a_byte : ~a_byte;
    adc2a_d   = (row.channel == scope_acq_pkg::CHANNEL_2) ? a_byte : ~a_byte;
    adc1b_d   = k[7:0];
    adc2b_d   = lcg_state[7:0];
  endtask

  task automatic sweep_readback();
    read_check = 1'b1;
    for (int a = READ_FIRST; a <= READ_LAST; a++)
    begin
      read_address = a[11:0];
      @(posedge sample_write_clock);
      #1;
    end
    read_check = 1'b0;
    @(posedge sample_write_clock);                   // Last word compared here
    #1;
  endtask

  task automatic run_scenario(input int idx);
    int          cycles;
    logic        done_seen;
    int unsigned k;
    row                 = scenario_table[idx];
    sample_system_reset = 1'b1;
    trigger_mode        = row.mode;
    trigger_edge        = row.trig_edge;
    trigger_channel     = row.channel;
    trigger_level       = row.level;
    time_base_set       = row.time_base;
    exp_triggered       = row.exp_triggered;
    exp_trigger_address = row.exp_trigger_address;
    repeat (4) @(posedge sample_write_clock);
    #1;
    sample_system_reset = 1'b0;
    lcg_state = LCG_SEED;
    k = 0;
    drive_sample(k);
    cycles    = 0;
    done_seen = 1'b0;
    while (!done_seen && cycles < DONE_TIMEOUT)
    begin
      @(posedge sample_write_clock);
      #1;
      cycles++;
      if (sampling_done)
        done_seen = 1'b1;
      else
      begin
        k++;
        drive_sample(k);
      end
    end
    if (done_seen == row.exp_done)
      $display("Scenario %0d: done %0b after %0d cycles as expected", idx, done_seen, cycles);
    else
    begin
      tb_errors++;
      if (!done_seen)
        $display("Scenario %0d: timed out after %0d cycles waiting for done", idx, cycles);
      else
        $display("Scenario %0d: sampling done arrived although none was expected", idx);
    end
    if (done_seen && row.exp_triggered)
      sweep_readback();
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial
  begin
    sample_system_reset = 1'b1;
    {adc1a_d, adc1b_d, adc2a_d, adc2b_d} = '0;
    trigger_mode        = scope_acq_pkg::MODE_NORMAL;
    trigger_edge        = scope_acq_pkg::EDGE_RISING;
    trigger_channel     = scope_acq_pkg::CHANNEL_1;
    trigger_level       = 8'h80;
    time_base_set       = '0;
    read_address        = '0;
    read_check          = 1'b0;
    exp_triggered       = 1'b0;
    exp_trigger_address = '0;
    lcg_state           = LCG_SEED;
    tb_errors           = 0;
    for (int i = 0; i < NUM_SCENARIOS; i++)
    begin
      run_scenario(i);
    end
    $display("Error counts: checker %0d, testbench %0d", checker_errors, tb_errors);
    if (checker_errors == 0 && tb_errors == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* scope_acquisition.f */
verilog/scope_acq_pkg.sv
verilog/sample_memory.sv
verilog/trigger_detector.sv
verilog/acquisition_control.sv
verilog/scope_acquisition.sv
tests/acq_checker.sv
tests/tb_scope_acquisition.sv

/* run_sim.sh */
#!/bin/sh
# Build the scope acquisition testbench with Verilator, run it into a log
# and decide pass or fail from the log contents

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_scope_acquisition -f scope_acquisition.f -o sim_scope_acquisition \
  && ./obj_dir/sim_scope_acquisition > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; } \
  || echo "Simulation reported no failure"
